// File: common/mont_pkg.sv
`default_nettype none

package mont_pkg;

    // Operand and internal widths
    localparam int OPERAND_W = 1024;
    // Four guard bits hold 3B, 3M and the signed difference
    localparam int ADDER_W = OPERAND_W + 4;

    // Adder handles one chunk per cycle
    localparam int CHUNK_W = 257;
    localparam int ADDER_CHUNKS = ADDER_W / CHUNK_W;
    localparam int CHUNK_IDX_W = $clog2(ADDER_CHUNKS);

    // Radix-4 digit loop
    localparam int ITERATIONS = OPERAND_W / 2;
    localparam int ITER_CNT_W = 10;

    typedef enum logic [3:0] {
        IDLE,
        PRE_3B,
        WAIT_3B,
        PRE_3M,
        WAIT_3M,
        ADD_B,
        WAIT_B,
        ADD_M,
        WAIT_M,
        SUB_M,
        WAIT_SUB,
        DONE
    } mont_state_e;

    typedef enum logic [2:0] {
        SEL_B_PLUS_2B,
        SEL_M_PLUS_2M,
        SEL_C_PLUS_DIGIT_B,
        SEL_C_PLUS_Q_M,
        SEL_C_MINUS_M
    } operand_sel_e;

    typedef struct packed {
        logic         load_inputs;
        operand_sel_e op_sel;
        logic         load_b3;
        logic         load_m3;
        logic         load_c;
        logic         shift_c;
        logic         shift_a;
        logic         reduce;
    } mont_ctrl_t;

    typedef struct packed {
        logic [ADDER_W-1:0] a;
        logic [ADDER_W-1:0] b;
        logic               subtract;
    } adder_req_t;

endpackage

`default_nettype wire

// File: hdl/mp_adder.sv
`default_nettype none

module mp_adder (
    input  wire                        clk,
    input  wire                        resetn,
    input  wire                        start,
    input  wire mont_pkg::adder_req_t  req,
    output logic [mont_pkg::ADDER_W:0] result,
    output logic                       done
);

    logic [mont_pkg::ADDER_W-1:0]     op_a;
    logic [mont_pkg::ADDER_W-1:0]     op_b;
    logic                             subtract_q;
    logic                             carry_q;
    logic                             busy;
    logic [mont_pkg::CHUNK_IDX_W-1:0] chunk_idx;
    logic [mont_pkg::CHUNK_IDX_W-1:0] slice;
    logic [mont_pkg::CHUNK_W-1:0]     chunk_a;
    logic [mont_pkg::CHUNK_W-1:0]     chunk_b;
    logic                             carry_in;
    logic [mont_pkg::CHUNK_W:0]       chunk_sum;

    // Slice 0 comes straight from the request in the start cycle
    always_comb begin
        if (start) begin
            slice    = '0;
            chunk_a  = req.a[mont_pkg::CHUNK_W-1:0];
            chunk_b  = req.subtract ? ~req.b[mont_pkg::CHUNK_W-1:0]
                                    : req.b[mont_pkg::CHUNK_W-1:0];
            carry_in = req.subtract;
        end else begin
            slice    = chunk_idx;
            chunk_a  = op_a[chunk_idx*mont_pkg::CHUNK_W +: mont_pkg::CHUNK_W];
            chunk_b  = op_b[chunk_idx*mont_pkg::CHUNK_W +: mont_pkg::CHUNK_W];
            carry_in = carry_q;
        end
        chunk_sum = {1'b0, chunk_a} + {1'b0, chunk_b} + {{mont_pkg::CHUNK_W{1'b0}}, carry_in};
    end

    // Operands and result slices
    always_ff @(posedge clk) begin
        if (start) begin
            op_a       <= req.a;
            op_b       <= req.subtract ? ~req.b : req.b;
            subtract_q <= req.subtract;
        end
        if (start || busy) begin
            result[slice*mont_pkg::CHUNK_W +: mont_pkg::CHUNK_W] <=
                chunk_sum[mont_pkg::CHUNK_W-1:0];
        end
        // Top bit is the carry for an add, the borrow for a subtract
        if (busy && chunk_idx == (mont_pkg::ADDER_CHUNKS - 1)) begin
            result[mont_pkg::ADDER_W] <= chunk_sum[mont_pkg::CHUNK_W] ^ subtract_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy      <= 1'b0;
            chunk_idx <= '0;
            carry_q   <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy      <= 1'b1;
                chunk_idx <= 1'b1;
                carry_q   <= chunk_sum[mont_pkg::CHUNK_W];
            end else if (busy) begin
                carry_q   <= chunk_sum[mont_pkg::CHUNK_W];
                chunk_idx <= chunk_idx + 1'b1;
                if (chunk_idx == (mont_pkg::ADDER_CHUNKS - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // The controller must wait for done before the next request
    a_no_start_when_busy: assert property (@(posedge clk) disable iff (!resetn)
        start |-> !busy);

endmodule

`default_nettype wire

// File: montgomery/mont_ctrl.sv
`default_nettype none

module mont_ctrl (
    input  wire                  clk,
    input  wire                  resetn,
    input  wire                  start,
    input  wire                  adder_done,
    output mont_pkg::mont_ctrl_t ctrl,
    output logic                 adder_start,
    output logic                 done
);

    mont_pkg::mont_state_e           state;
    mont_pkg::mont_state_e           next_state;
    logic [mont_pkg::ITER_CNT_W-1:0] iter_cnt;
    logic                            last_iter;

    assign last_iter = (iter_cnt == (mont_pkg::ITERATIONS - 1));

    always_comb begin
        next_state = state;
        case (state)
            mont_pkg::IDLE: begin
                if (start) begin
                    next_state = mont_pkg::PRE_3B;
                end
            end
            mont_pkg::PRE_3B:   next_state = mont_pkg::WAIT_3B;
            mont_pkg::WAIT_3B: begin
                if (adder_done) begin
                    next_state = mont_pkg::PRE_3M;
                end
            end
            mont_pkg::PRE_3M:   next_state = mont_pkg::WAIT_3M;
            mont_pkg::WAIT_3M: begin
                if (adder_done) begin
                    next_state = mont_pkg::ADD_B;
                end
            end
            mont_pkg::ADD_B:    next_state = mont_pkg::WAIT_B;
            mont_pkg::WAIT_B: begin
                if (adder_done) begin
                    next_state = mont_pkg::ADD_M;
                end
            end
            mont_pkg::ADD_M:    next_state = mont_pkg::WAIT_M;
            mont_pkg::WAIT_M: begin
                if (adder_done) begin
                    next_state = last_iter ? mont_pkg::SUB_M : mont_pkg::ADD_B;
                end
            end
            mont_pkg::SUB_M:    next_state = mont_pkg::WAIT_SUB;
            mont_pkg::WAIT_SUB: begin
                if (adder_done) begin
                    next_state = mont_pkg::DONE;
                end
            end
            default:            next_state = mont_pkg::IDLE;
        endcase
    end

    // Datapath loads land on the adder done cycle
    always_comb begin
        ctrl = '0;
        ctrl.op_sel = mont_pkg::SEL_B_PLUS_2B;
        case (state)
            mont_pkg::IDLE: ctrl.load_inputs = start;
            mont_pkg::WAIT_3B: ctrl.load_b3 = adder_done;
            mont_pkg::PRE_3M, mont_pkg::WAIT_3M: begin
                ctrl.op_sel  = mont_pkg::SEL_M_PLUS_2M;
                ctrl.load_m3 = (state == mont_pkg::WAIT_3M) && adder_done;
            end
            mont_pkg::ADD_B, mont_pkg::WAIT_B: begin
                ctrl.op_sel = mont_pkg::SEL_C_PLUS_DIGIT_B;
                ctrl.load_c = (state == mont_pkg::WAIT_B) && adder_done;
            end
            mont_pkg::ADD_M, mont_pkg::WAIT_M: begin
                ctrl.op_sel  = mont_pkg::SEL_C_PLUS_Q_M;
                ctrl.shift_c = (state == mont_pkg::WAIT_M) && adder_done;
                ctrl.shift_a = (state == mont_pkg::WAIT_M) && adder_done;
            end
            mont_pkg::SUB_M, mont_pkg::WAIT_SUB: begin
                ctrl.op_sel = mont_pkg::SEL_C_MINUS_M;
                ctrl.reduce = (state == mont_pkg::WAIT_SUB) && adder_done;
            end
            default: ctrl.op_sel = mont_pkg::SEL_B_PLUS_2B;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state       <= mont_pkg::IDLE;
            iter_cnt    <= '0;
            adder_start <= 1'b0;
            done        <= 1'b0;
        end else begin
            state       <= next_state;
            adder_start <= next_state inside {mont_pkg::PRE_3B, mont_pkg::PRE_3M,
                                              mont_pkg::ADD_B, mont_pkg::ADD_M,
                                              mont_pkg::SUB_M};
            done        <= (next_state == mont_pkg::DONE);
            if (state == mont_pkg::IDLE) begin
                iter_cnt <= '0;
            end else if (state == mont_pkg::WAIT_M && adder_done) begin
                iter_cnt <= iter_cnt + 1'b1;
            end
        end
    end

    // A wait state holds start low until the adder reports done
    a_start_not_in_wait: assert property (@(posedge clk) disable iff (!resetn)
        (state inside {mont_pkg::WAIT_3B, mont_pkg::WAIT_3M,
                       mont_pkg::WAIT_B, mont_pkg::WAIT_M,
                       mont_pkg::WAIT_SUB}) && !adder_done |=> !adder_start);

    a_done_only_in_done: assert property (@(posedge clk) disable iff (!resetn)
        done |-> state == mont_pkg::DONE
                 && $past(state == mont_pkg::WAIT_SUB && adder_done));

endmodule

`default_nettype wire

// File: montgomery/mont_datapath.sv
`default_nettype none

module mont_datapath (
    input  wire                          clk,
    input  wire                          resetn,
    input  wire [mont_pkg::OPERAND_W-1:0] in_a,
    input  wire [mont_pkg::OPERAND_W-1:0] in_b,
    input  wire [mont_pkg::OPERAND_W-1:0] in_m,
    input  wire mont_pkg::mont_ctrl_t     ctrl,
    input  wire [mont_pkg::ADDER_W:0]     adder_result,
    output mont_pkg::adder_req_t          adder_req,
    output logic [mont_pkg::OPERAND_W-1:0] result
);

    logic [mont_pkg::OPERAND_W-1:0] a;
    logic [mont_pkg::OPERAND_W-1:0] b;
    logic [mont_pkg::OPERAND_W-1:0] m;
    logic [mont_pkg::ADDER_W-1:0]   b3;
    logic [mont_pkg::ADDER_W-1:0]   m3;
    logic [mont_pkg::ADDER_W-1:0]   c;
    logic [mont_pkg::ADDER_W-1:0]   b_ext;
    logic [mont_pkg::ADDER_W-1:0]   m_ext;
    logic [mont_pkg::ADDER_W-1:0]   digit_b;
    logic [mont_pkg::ADDER_W-1:0]   q_m;
    logic [3:0]                     cm_prod;
    logic [1:0]                     q_digit;

    assign b_ext = {4'b0, b};
    assign m_ext = {4'b0, m};

    // Multiple of B picked by the current digit of a
    always_comb begin
        case (a[1:0])
            2'd0:    digit_b = '0;
            2'd1:    digit_b = b_ext;
            2'd2:    digit_b = {b_ext[mont_pkg::ADDER_W-2:0], 1'b0};
            default: digit_b = b3;
        endcase
    end

    // For odd m, m is its own inverse mod 4, so q = -c*m mod 4
    assign cm_prod = c[1:0] * m[1:0];
    assign q_digit = ~cm_prod[1:0] + 2'd1;

    always_comb begin
        case (q_digit)
            2'd0:    q_m = '0;
            2'd1:    q_m = m_ext;
            2'd2:    q_m = {m_ext[mont_pkg::ADDER_W-2:0], 1'b0};
            default: q_m = m3;
        endcase
    end

    always_comb begin
        adder_req.subtract = 1'b0;
        case (ctrl.op_sel)
            mont_pkg::SEL_B_PLUS_2B: begin
                adder_req.a = b_ext;
                adder_req.b = {b_ext[mont_pkg::ADDER_W-2:0], 1'b0};
            end
            mont_pkg::SEL_M_PLUS_2M: begin
                adder_req.a = m_ext;
                adder_req.b = {m_ext[mont_pkg::ADDER_W-2:0], 1'b0};
            end
            mont_pkg::SEL_C_PLUS_DIGIT_B: begin
                adder_req.a = c;
                adder_req.b = digit_b;
            end
            mont_pkg::SEL_C_PLUS_Q_M: begin
                adder_req.a = c;
                adder_req.b = q_m;
            end
            default: begin
                adder_req.a        = c;
                adder_req.b        = m_ext;
                adder_req.subtract = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            a  <= '0;
            b  <= '0;
            m  <= '0;
            b3 <= '0;
            m3 <= '0;
            c  <= '0;
        end else begin
            if (ctrl.load_inputs) begin
                a <= in_a;
                b <= in_b;
                m <= in_m;
                c <= '0;
            end
            if (ctrl.shift_a) begin
                a <= {2'b00, a[mont_pkg::OPERAND_W-1:2]};
            end
            if (ctrl.load_b3) begin
                b3 <= adder_result[mont_pkg::ADDER_W-1:0];
            end
            if (ctrl.load_m3) begin
                m3 <= adder_result[mont_pkg::ADDER_W-1:0];
            end
            if (ctrl.load_c) begin
                c <= adder_result[mont_pkg::ADDER_W-1:0];
            end
            // Low two bits are zero here by choice of q
            if (ctrl.shift_c) begin
                c <= {1'b0, adder_result[mont_pkg::ADDER_W:2]};
            end
            // Keep c - m only when the subtraction did not borrow
            if (ctrl.reduce && !adder_result[mont_pkg::ADDER_W]) begin
                c <= adder_result[mont_pkg::ADDER_W-1:0];
            end
        end
    end

    assign result = c[mont_pkg::OPERAND_W-1:0];

    a_modulus_odd: assert property (@(posedge clk) disable iff (!resetn)
        ctrl.load_inputs |=> m[0]);

    a_c_below_2m: assert property (@(posedge clk) disable iff (!resetn)
        ctrl.reduce |-> c < {3'b0, m, 1'b0});

endmodule

`default_nettype wire

// File: montgomery/montgomery_top.sv
`default_nettype none

module montgomery_top (
    input  wire                           clk,
    input  wire                           resetn,
    input  wire                           start,
    input  wire [mont_pkg::OPERAND_W-1:0] in_a,
    input  wire [mont_pkg::OPERAND_W-1:0] in_b,
    input  wire [mont_pkg::OPERAND_W-1:0] in_m,
    output logic [mont_pkg::OPERAND_W-1:0] result,
    output logic                          done
);

    mont_pkg::mont_ctrl_t       ctrl;
    mont_pkg::adder_req_t       adder_req;
    logic [mont_pkg::ADDER_W:0] adder_result;
    logic                       adder_start;
    logic                       adder_done;

    mont_ctrl mont_ctrl_inst (
        .clk         (clk),
        .resetn      (resetn),
        .start       (start),
        .adder_done  (adder_done),
        .ctrl        (ctrl),
        .adder_start (adder_start),
        .done        (done)
    );

    mont_datapath mont_datapath_inst (
        .clk          (clk),
        .resetn       (resetn),
        .in_a         (in_a),
        .in_b         (in_b),
        .in_m         (in_m),
        .ctrl         (ctrl),
        .adder_result (adder_result),
        .adder_req    (adder_req),
        .result       (result)
    );

    // Adder runs on the global reset
    mp_adder mp_adder_inst (
        .clk    (clk),
        .resetn (resetn),
        .start  (adder_start),
        .req    (adder_req),
        .result (adder_result),
        .done   (adder_done)
    );

endmodule

`default_nettype wire

// File: dv/montgomery_tb.sv
`default_nettype none

module montgomery_tb;

    timeunit 1ns;
    timeprecision 1ns;

    localparam int W = mont_pkg::OPERAND_W;
    localparam int CLK_PERIOD = 100;
    // Generous bound on one operation of one cycle more than the chunks per adder pass
    localparam int OP_CYCLES = (mont_pkg::ADDER_CHUNKS + 1) * (2 * mont_pkg::ITERATIONS + 3)
                               + 32;
    localparam int OP_TIMEOUT = 2 * OP_CYCLES;
    localparam int TOTAL_OPS = 32;
    localparam longint WATCHDOG_NS = longint'(TOTAL_OPS) * OP_TIMEOUT * CLK_PERIOD;

    logic         clk = 1'b0;
    logic         resetn;
    logic         start;
    logic [W-1:0] in_a;
    logic [W-1:0] in_b;
    logic [W-1:0] in_m;
    logic [W-1:0] result;
    logic         done;

    integer       seed = 32'hc38c_3c68;
    integer       errors = 0;
    integer       checks = 0;
    logic [W-1:0] last_result;

    montgomery_top montgomery_top_inst (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .in_a   (in_a),
        .in_b   (in_b),
        .in_m   (in_m),
        .result (result),
        .done   (done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic rand_wide(output logic [W-1:0] v);
        integer i;
        for (i = 0; i < W / 32; i++) begin
            v[i*32 +: 32] = $random(seed);
        end
    endtask

    task automatic start_op(input logic [W-1:0] a, input logic [W-1:0] b,
                            input logic [W-1:0] m);
        @(posedge clk);
        in_a  <= a;
        in_b  <= b;
        in_m  <= m;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // Samples done on the falling edge
    task automatic wait_done(input string name, output bit ok);
        integer n;
        n  = 0;
        ok = 1'b0;
        while (!ok && n < OP_TIMEOUT) begin
            @(negedge clk);
            if (done) begin
                ok = 1'b1;
            end
            n++;
        end
        checks++;
        if (!ok) begin
            errors++;
            $display("%s: no done pulse within %0d cycles", name, OP_TIMEOUT);
        end
    endtask

    // Model checks result*2^W == a*b (mod m)
    task automatic check_relation(input string name, input logic [W-1:0] a,
                                  input logic [W-1:0] b, input logic [W-1:0] m,
                                  input logic [W-1:0] res);
        logic [2*W-1:0] m_w;
        logic [2*W-1:0] prod;
        logic [2*W-1:0] exp_v;
        logic [2*W-1:0] act_v;
        m_w   = {{W{1'b0}}, m};
        prod  = {{W{1'b0}}, a} * {{W{1'b0}}, b};
        exp_v = prod % m_w;
        act_v = {res, {W{1'b0}}} % m_w;
        checks++;
        if (res >= m) begin
            errors++;
            $display("MISMATCH %s: expected result below %h, actual %h", name, m, res);
        end
        checks++;
        if (act_v !== exp_v) begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", name,
                     exp_v[W-1:0], act_v[W-1:0]);
        end
    endtask

    task automatic run_op(input string name, input logic [W-1:0] a,
                          input logic [W-1:0] b, input logic [W-1:0] m);
        bit ok;
        start_op(a, b, m);
        wait_done(name, ok);
        if (ok) begin
            last_result = result;
            check_relation(name, a, b, m, result);
            @(negedge clk);
            checks++;
            if (done) begin
                errors++;
                $display("%s: done stayed high longer than one cycle", name);
            end
        end
    endtask

    task automatic rand_operands(output logic [W-1:0] a, output logic [W-1:0] b,
                                 output logic [W-1:0] m);
        rand_wide(m);
        m[W-1] = 1'b1;
        m[0]   = 1'b1;
        rand_wide(a);
        rand_wide(b);
        a = a % m;
        b = b % m;
    endtask

    initial begin
        logic [W-1:0] a;
        logic [W-1:0] b;
        logic [W-1:0] m;
        logic [W-1:0] new_a;
        logic [W-1:0] res1;
        logic [31:0]  r;
        bit           ok;
        integer       i;
        integer       extra_done;

        resetn = 1'b0;
        start  = 1'b0;
        in_a   = '0;
        in_b   = '0;
        in_m   = '0;
        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        checks++;
        if (done !== 1'b0) begin
            errors++;
            $display("done is not low right after reset");
        end

        for (i = 0; i < 20; i++) begin
            rand_operands(a, b, m);
            run_op($sformatf("random_%0d", i), a, b, m);
        end

        // Edge operands
        rand_operands(a, b, m);
        run_op("zero_a", '0, b, m);
        checks++;
        if (last_result !== '0) begin
            errors++;
            $display("MISMATCH zero_a: expected %h, actual %h", {W{1'b0}}, last_result);
        end
        m = '1;
        run_op("max_modulus", m - 1, m - 1, m);
        run_op("small_modulus", 1, 2, 3);

        // Operands near m push the value before the final subtraction above m
        for (i = 0; i < 4; i++) begin
            rand_operands(a, b, m);
            r = $random(seed);
            run_op($sformatf("near_modulus_%0d", i), m - 1 - r[7:0], m - 1 - r[15:8], m);
        end

        // Second start during an operation must be ignored
        rand_operands(a, b, m);
        start_op(a, b, m);
        repeat (200) @(posedge clk);
        rand_wide(new_a);
        in_a  <= new_a;
        in_m  <= 3;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        wait_done("start_while_busy", ok);
        res1 = result;
        if (ok) begin
            check_relation("start_while_busy", a, b, m, res1);
        end
        extra_done = 0;
        repeat (OP_CYCLES) begin
            @(negedge clk);
            if (done) begin
                extra_done++;
            end
        end
        checks++;
        if (extra_done != 0) begin
            errors++;
            $display("start_while_busy: %0d extra done pulses seen", extra_done);
        end
        checks++;
        if (result !== res1) begin
            errors++;
            $display("MISMATCH start_while_busy_hold: expected %h, actual %h", res1, result);
        end

        // Reset in the middle of an operation
        rand_operands(a, b, m);
        start_op(a, b, m);
        repeat (1500) @(posedge clk);
        resetn <= 1'b0;
        repeat (5) begin
            @(negedge clk);
            checks++;
            if (done !== 1'b0) begin
                errors++;
                $display("mid_reset: done was not low during reset");
            end
        end
        @(posedge clk);
        resetn <= 1'b1;
        repeat (3) begin
            @(negedge clk);
            checks++;
            if (done !== 1'b0) begin
                errors++;
                $display("mid_reset: done was not low after reset release");
            end
        end
        rand_operands(a, b, m);
        run_op("after_reset", a, b, m);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the test did not complete", WATCHDOG_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
common/mont_pkg.sv
hdl/mp_adder.sv
montgomery/mont_ctrl.sv
montgomery/mont_datapath.sv
montgomery/montgomery_top.sv
dv/montgomery_tb.sv

// File: Bender.yml
package:
  name: montgomery

sources:
  - common/mont_pkg.sv
  - hdl/mp_adder.sv
  - montgomery/mont_ctrl.sv
  - montgomery/mont_datapath.sv
  - montgomery/montgomery_top.sv
  - target: test
    files:
      - dv/montgomery_tb.sv
